// File: common/imuldiv_pkg.sv
//--------------------------------------------------------------------------
// shared widths, function codes and iteration state for the muldiv unit
// imported with a wildcard import by every RTL module and the testbench
//--------------------------------------------------------------------------

package imuldiv_pkg;

  //--------------------------------------------------------------------------
  // data widths
  //--------------------------------------------------------------------------

  localparam int WORD_W  = 32;
  localparam int DWORD_W = 2 * WORD_W;

  // one operand, quotient or remainder
  typedef logic [WORD_W-1:0] word_t;

  // full result: product, or {remainder, quotient} for a divide
  typedef logic [DWORD_W-1:0] dword_t;

  //--------------------------------------------------------------------------
  // function codes
  //--------------------------------------------------------------------------

  typedef logic [1:0] fn_t;

  localparam fn_t FN_MUL  = 2'd0;
  localparam fn_t FN_DIV  = 2'd1;
  localparam fn_t FN_DIVU = 2'd2;
  // code 3 is unused, the router treats it as a signed divide

  //--------------------------------------------------------------------------
  // iteration control
  //--------------------------------------------------------------------------

  // one bit per iteration for both units
  localparam int NUM_ITER = 32;

  typedef logic [$clog2(NUM_ITER)-1:0] count_t;

  // counter value seen in the final CALC cycle
  localparam count_t LAST_ITER = count_t'(NUM_ITER - 1);

  // shared by the multiplier and divider control FSMs
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } iter_state_t;

endpackage

// File: imul/imul_iterative_dpath.sv
//--------------------------------------------------------------------------
// shift-and-add datapath for the iterative signed multiplier
// driven by load/step from the multiplier control FSM
//--------------------------------------------------------------------------

module imul_iterative_dpath import imuldiv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  word_t  msg_a,
  input  word_t  msg_b,
  input  logic   load,
  input  logic   step,
  output dword_t result
);

  // captured operand signs
  logic sign_a;
  logic sign_b;

  // multiplicand grows left, multiplier shrinks right
  dword_t a_reg;
  word_t  b_reg;
  dword_t acc;

  // magnitudes of the incoming operands
  word_t mag_a;
  word_t mag_b;

  // partial sum for this step
  dword_t acc_next;

  // two's complement magnitude, 0x80000000 stays as an unsigned value
  assign mag_a = msg_a[WORD_W-1] ? (~msg_a + word_t'(1)) : msg_a;
  assign mag_b = msg_b[WORD_W-1] ? (~msg_b + word_t'(1)) : msg_b;

  // add the shifted multiplicand only when the current multiplier bit is set
  assign acc_next = b_reg[0] ? (acc + a_reg) : acc;

  //--------------------------------------------------------------------------
  // signs and accumulator
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a <= 1'b0;
      sign_b <= 1'b0;
      acc    <= '0;
    end else if (load) begin
      sign_a <= msg_a[WORD_W-1];
      sign_b <= msg_b[WORD_W-1];
      acc    <= '0;
    end else if (step) begin
      acc <= acc_next;
    end
  end

  //--------------------------------------------------------------------------
  // operand shift registers
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      // zero extend the multiplicand magnitude to the full width
      a_reg <= {{WORD_W{1'b0}}, mag_a};
      b_reg <= mag_b;
    end else if (step) begin
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // negate the unsigned product when exactly one operand was negative
  assign result = (sign_a ^ sign_b) ? (~acc + dword_t'(1)) : acc;

endmodule

// File: imul/imul_iterative.sv
//--------------------------------------------------------------------------
// iterative multiplier unit with val/rdy request and response ports
// holds one operation at a time, result valid 32 steps after the accept
//--------------------------------------------------------------------------

module imul_iterative import imuldiv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  word_t  req_msg_a,
  input  word_t  req_msg_b,
  input  logic   req_val,
  output logic   req_rdy,
  output dword_t resp_result,
  output logic   resp_val,
  input  logic   resp_rdy
);

  iter_state_t state;
  count_t      count;

  // datapath controls
  logic load;
  logic step;

  // handshakes
  logic req_go;
  logic resp_go;

  //--------------------------------------------------------------------------
  // control FSM
  //--------------------------------------------------------------------------

  // only IDLE takes a new operation, so at most one is in flight
  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // load on the accept edge, step on every CALC cycle
  assign load = req_go;
  assign step = (state == CALC);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // the step taken in the last count still lands before DONE
          if (count == LAST_ITER) begin
            state <= DONE;
          end else begin
            count <= count + count_t'(1);
          end
        end
        DONE: begin
          // result is held until the response side takes it
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  imul_iterative_dpath u_dpath (
    .clk    (clk),
    .reset  (reset),
    .msg_a  (req_msg_a),
    .msg_b  (req_msg_b),
    .load   (load),
    .step   (step),
    .result (resp_result)
  );

endmodule

// File: idiv/idiv_iterative_dpath.sv
//--------------------------------------------------------------------------
// restoring divider datapath, signed or unsigned by the is_signed input
// result is {remainder, quotient}; load/step come from the divider FSM
//--------------------------------------------------------------------------

module idiv_iterative_dpath import imuldiv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  word_t  msg_a,
  input  word_t  msg_b,
  input  logic   is_signed,
  input  logic   load,
  input  logic   step,
  output dword_t result
);

  // signs only count for a signed divide
  logic sign_a;
  logic sign_b;
  logic div_zero;

  // divisor magnitude and {remainder, quotient} shift register
  word_t  b_mag;
  dword_t rq;

  // incoming operand signs and magnitudes
  logic  neg_a;
  logic  neg_b;
  word_t mag_a;
  word_t mag_b;

  // trial subtraction, one guard bit to catch a borrow
  dword_t             rq_shift;
  logic [WORD_W:0]    diff;

  // remainder and quotient after sign fixing
  word_t rem_out;
  word_t quo_out;

  assign neg_a = is_signed && msg_a[WORD_W-1];
  assign neg_b = is_signed && msg_b[WORD_W-1];
  assign mag_a = neg_a ? (~msg_a + word_t'(1)) : msg_a;
  assign mag_b = neg_b ? (~msg_b + word_t'(1)) : msg_b;

  assign rq_shift = rq << 1;
  assign diff     = {1'b0, rq_shift[DWORD_W-1:WORD_W]} - {1'b0, b_mag};

  //--------------------------------------------------------------------------
  // sign and divide-by-zero flags
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a   <= 1'b0;
      sign_b   <= 1'b0;
      div_zero <= 1'b0;
    end else if (load) begin
      sign_a   <= neg_a;
      sign_b   <= neg_b;
      div_zero <= (msg_b == '0);
    end
  end

  //--------------------------------------------------------------------------
  // remainder/quotient iteration
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      b_mag <= mag_b;
      rq    <= {{WORD_W{1'b0}}, mag_a};
    end else if (step) begin
      // keep the difference and set the quotient bit when no borrow
      if (!diff[WORD_W]) begin
        rq <= {diff[WORD_W-1:0], rq_shift[WORD_W-1:1], 1'b1};
      end else begin
        rq <= rq_shift;
      end
    end
  end

  // remainder follows the dividend, quotient the xor of the signs
  // with a zero divisor the remainder already works out to the dividend
  assign rem_out = sign_a ? (~rq[DWORD_W-1:WORD_W] + word_t'(1)) : rq[DWORD_W-1:WORD_W];
  assign quo_out = div_zero         ? '1 :
                   (sign_a ^ sign_b) ? (~rq[WORD_W-1:0] + word_t'(1)) : rq[WORD_W-1:0];

  assign result = {rem_out, quo_out};

endmodule

// File: idiv/idiv_iterative.sv
//--------------------------------------------------------------------------
// iterative divider unit with val/rdy request and response ports
// req_signed picks signed or unsigned divide for the accepted request
//--------------------------------------------------------------------------

module idiv_iterative import imuldiv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  word_t  req_msg_a,
  input  word_t  req_msg_b,
  input  logic   req_signed,
  input  logic   req_val,
  output logic   req_rdy,
  output dword_t resp_result,
  output logic   resp_val,
  input  logic   resp_rdy
);

  iter_state_t state;
  count_t      count;

  // datapath controls
  logic load;
  logic step;

  // handshakes
  logic req_go;
  logic resp_go;

  //--------------------------------------------------------------------------
  // control FSM
  //--------------------------------------------------------------------------

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  assign load = req_go;
  assign step = (state == CALC);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // one quotient bit per cycle, msb first
          if (count == LAST_ITER) begin
            state <= DONE;
          end else begin
            count <= count + count_t'(1);
          end
        end
        DONE: begin
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // signedness is latched inside the datapath together with the operands
  idiv_iterative_dpath u_dpath (
    .clk       (clk),
    .reset     (reset),
    .msg_a     (req_msg_a),
    .msg_b     (req_msg_b),
    .is_signed (req_signed),
    .load      (load),
    .step      (step),
    .result    (resp_result)
  );

endmodule

// File: hdl/imuldiv_port_router.sv
//--------------------------------------------------------------------------
// steers requests to the multiplier or divider by function code and
// shares the one response port between them round-robin
//--------------------------------------------------------------------------

module imuldiv_port_router import imuldiv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  // request side
  input  fn_t    req_fn,
  input  logic   req_val,
  output logic   req_rdy,
  output logic   mul_req_val,
  input  logic   mul_req_rdy,
  output logic   div_req_val,
  input  logic   div_req_rdy,
  output logic   div_signed,
  // response side
  input  logic   mul_resp_val,
  input  dword_t mul_resp_result,
  output logic   mul_resp_rdy,
  input  logic   div_resp_val,
  input  dword_t div_resp_result,
  output logic   div_resp_rdy,
  output logic   resp_val,
  output dword_t resp_result,
  output logic   resp_src,
  input  logic   resp_rdy
);

  logic to_mul;
  logic grant_mul;
  logic grant_div;
  // set when the divider won the last response transfer
  logic last_div;

  //--------------------------------------------------------------------------
  // request steering
  //--------------------------------------------------------------------------

  // anything but a multiply goes to the divider, unknown codes as signed
  assign to_mul      = (req_fn == FN_MUL);
  assign req_rdy     = to_mul ? mul_req_rdy : div_req_rdy;
  assign mul_req_val = req_val && to_mul;
  assign div_req_val = req_val && !to_mul;
  assign div_signed  = (req_fn != FN_DIVU);

  //--------------------------------------------------------------------------
  // response arbitration
  //--------------------------------------------------------------------------

  // on a tie the unit that lost last time goes first
  assign grant_div = div_resp_val && (!mul_resp_val || !last_div);
  assign grant_mul = mul_resp_val && !grant_div;

  assign resp_val     = mul_resp_val || div_resp_val;
  assign resp_src     = grant_div;
  assign resp_result  = grant_div ? div_resp_result : mul_resp_result;
  assign mul_resp_rdy = resp_rdy && grant_mul;
  assign div_resp_rdy = resp_rdy && grant_div;

  // grant stays put under back-pressure since this moves only on a transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      last_div <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      last_div <= grant_div;
    end
  end

endmodule

// File: hdl/imuldiv_iterative.sv
//--------------------------------------------------------------------------
// top of the iterative multiply/divide unit: router plus two peer units
// one request port and one response port, resp_src names the unit
//--------------------------------------------------------------------------

module imuldiv_iterative import imuldiv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  word_t  req_msg_a,
  input  word_t  req_msg_b,
  input  fn_t    req_fn,
  input  logic   req_val,
  output logic   req_rdy,
  output logic   resp_val,
  output dword_t resp_result,
  output logic   resp_src,
  input  logic   resp_rdy
);

  // router to multiplier
  logic   mul_req_val;
  logic   mul_req_rdy;
  logic   mul_resp_val;
  logic   mul_resp_rdy;
  dword_t mul_resp_result;

  // router to divider
  logic   div_req_val;
  logic   div_req_rdy;
  logic   div_signed;
  logic   div_resp_val;
  logic   div_resp_rdy;
  dword_t div_resp_result;

  imuldiv_port_router u_router (
    .clk             (clk),
    .reset           (reset),
    .req_fn          (req_fn),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .mul_req_val     (mul_req_val),
    .mul_req_rdy     (mul_req_rdy),
    .div_req_val     (div_req_val),
    .div_req_rdy     (div_req_rdy),
    .div_signed      (div_signed),
    .mul_resp_val    (mul_resp_val),
    .mul_resp_result (mul_resp_result),
    .mul_resp_rdy    (mul_resp_rdy),
    .div_resp_val    (div_resp_val),
    .div_resp_result (div_resp_result),
    .div_resp_rdy    (div_resp_rdy),
    .resp_val        (resp_val),
    .resp_result     (resp_result),
    .resp_src        (resp_src),
    .resp_rdy        (resp_rdy)
  );

  // operands fan out to both units, only the selected one sees req_val
  imul_iterative u_imul (
    .clk         (clk),
    .reset       (reset),
    .req_msg_a   (req_msg_a),
    .req_msg_b   (req_msg_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy)
  );

  idiv_iterative u_idiv (
    .clk         (clk),
    .reset       (reset),
    .req_msg_a   (req_msg_a),
    .req_msg_b   (req_msg_b),
    .req_signed  (div_signed),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_result (div_resp_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy)
  );

endmodule

// File: testbench/tb_imuldiv.sv
//--------------------------------------------------------------------------
// testbench for the iterative multiply/divide unit
// directed and random requests, reference model per unit, assertion checks
//--------------------------------------------------------------------------

module tb_imuldiv import imuldiv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 400;

  logic   clk;
  logic   reset;
  word_t  req_msg_a;
  word_t  req_msg_b;
  fn_t    req_fn;
  logic   req_val;
  logic   req_rdy;
  logic   resp_val;
  dword_t resp_result;
  logic   resp_src;
  logic   resp_rdy;

  // expected results per unit in issue order
  dword_t exp_mul[$];
  dword_t exp_div[$];

  int     err_count;
  int     tests_passed;
  int     tests_failed;
  int     seed;

  imuldiv_iterative u_dut (
    .clk         (clk),
    .reset       (reset),
    .req_msg_a   (req_msg_a),
    .req_msg_b   (req_msg_b),
    .req_fn      (req_fn),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_result (resp_result),
    .resp_src    (resp_src),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------

  function automatic dword_t signed_product(word_t a, word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = 64'($signed(a));
    sb = 64'($signed(b));
    return dword_t'(sa * sb);
  endfunction

  // packs {remainder, quotient} with the remainder sign following the dividend
  function automatic dword_t divide_result(word_t a, word_t b, logic sgn);
    word_t q;
    word_t r;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      q = 32'h8000_0000;
      r = '0;
    end else if (sgn) begin
      q = word_t'($signed(a) / $signed(b));
      r = word_t'($signed(a) % $signed(b));
    end else begin
      q = a / b;
      r = a % b;
    end
    return {r, q};
  endfunction

  //--------------------------------------------------------------------------
  // monitor that records accepts and checks every response transfer
  //--------------------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset && req_val && req_rdy) begin
      if (req_fn == FN_MUL) begin
        exp_mul.push_back(signed_product(req_msg_a, req_msg_b));
      end else begin
        exp_div.push_back(divide_result(req_msg_a, req_msg_b, req_fn != FN_DIVU));
      end
    end
    if (!reset && resp_val && resp_rdy) begin
      if ((resp_src ? exp_div.size() : exp_mul.size()) == 0) begin
        $display("response from unit %0d with no request outstanding", resp_src);
        err_count++;
      end else if (resp_src) begin
        assert (resp_result == exp_div[0]) else begin
          $display("mismatch resp_result div: got %h expected %h", resp_result, exp_div[0]);
          err_count++;
        end
        void'(exp_div.pop_front());
      end else begin
        assert (resp_result == exp_mul[0]) else begin
          $display("mismatch resp_result mul: got %h expected %h", resp_result, exp_mul[0]);
          err_count++;
        end
        void'(exp_mul.pop_front());
      end
    end
  end

  // a stalled response holds its value and source
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result) && $stable(resp_src)))
  else begin
    $display("response changed while resp_rdy was low");
    err_count++;
  end

  // nothing is pending right after reset
  assert property (@(posedge clk) $past(reset) |-> !resp_val)
  else begin
    $display("mismatch resp_val after reset: got %h expected 0", resp_val);
    err_count++;
  end

  //--------------------------------------------------------------------------
  // stimulus tasks called on a falling edge
  //--------------------------------------------------------------------------

  task automatic apply_reset();
    reset = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic send_req(input fn_t fn, input word_t a, input word_t b);
    int waited;
    waited = 0;
    req_fn    = fn;
    req_msg_a = a;
    req_msg_b = b;
    req_val   = 1'b1;
    @(posedge clk);
    while (!req_rdy && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) begin
      $display("timeout waiting for req_rdy, fn %0d", fn);
      err_count++;
    end
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_mul.size() != 0 || exp_div.size() != 0 || resp_val)
           && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) begin
      $display("timeout waiting for outstanding responses");
      err_count++;
    end
  endtask

  // latency from the accept edge counted on falling edges
  task automatic check_latency(input fn_t fn, input word_t a, input word_t b);
    int cycles;
    send_req(fn, a, b);
    cycles = 1;
    // the same unit must now refuse work
    req_fn = fn;
    #1;
    assert (!req_rdy) else begin
      $display("mismatch req_rdy busy fn %0d: got %h expected 0", fn, req_rdy);
      err_count++;
    end
    while (!resp_val && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= WAIT_LIMIT) begin
      $display("timeout waiting for resp_val, fn %0d", fn);
      err_count++;
    end else begin
      assert (cycles == NUM_ITER + 1) else begin
        $display("mismatch latency fn %0d: got %h expected %h", fn, cycles, NUM_ITER + 1);
        err_count++;
      end
    end
    wait_drain();
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, err_count - errs_before);
    end
  endtask

  //--------------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------------

  initial begin
    int    errs;
    int    i;
    word_t a;
    word_t b;
    seed         = 32'ha121;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    reset        = 1'b1;
    req_msg_a    = '0;
    req_msg_b    = '0;
    req_fn       = FN_MUL;
    req_val      = 1'b0;
    resp_rdy     = 1'b1;
    @(negedge clk);
    apply_reset();

    // every code sees ready and nothing is pending
    errs = err_count;
    for (i = 0; i < 4; i++) begin
      req_fn = fn_t'(i);
      #1;
      assert (req_rdy) else begin
        $display("mismatch req_rdy fn %0d: got %h expected 1", i, req_rdy);
        err_count++;
      end
      assert (!resp_val) else begin
        $display("mismatch resp_val fn %0d: got %h expected 0", i, resp_val);
        err_count++;
      end
    end
    @(negedge clk);
    end_test("reset", errs);

    errs = err_count;
    send_req(FN_MUL, 32'h0000_0007, 32'hffff_fffd);
    send_req(FN_MUL, 32'h0000_0000, 32'h1234_5678);
    send_req(FN_MUL, 32'h8000_0000, 32'h8000_0000);
    send_req(FN_MUL, 32'h8000_0000, 32'h0000_0001);
    send_req(FN_MUL, 32'hffff_ffff, 32'hffff_ffff);
    for (i = 0; i < 8; i++) begin
      a = $random(seed);
      b = $random(seed);
      send_req(FN_MUL, a, b);
    end
    wait_drain();
    end_test("multiply", errs);

    errs = err_count;
    send_req(FN_DIV, 32'hffff_ff9c, 32'h0000_0007);
    send_req(FN_DIV, 32'h0000_0064, 32'hffff_fff9);
    send_req(FN_DIV, 32'hffff_ff9c, 32'hffff_fff9);
    send_req(FN_DIV, 32'h8000_0000, 32'hffff_ffff);
    send_req(FN_DIVU, 32'hffff_ff9c, 32'h0000_0007);
    send_req(2'd3, 32'hffff_ff9c, 32'h0000_0007);
    for (i = 0; i < 8; i++) begin
      a = $random(seed);
      b = $random(seed);
      send_req((i % 2 == 0) ? FN_DIV : FN_DIVU, a, b >> (i * 3));
    end
    wait_drain();
    end_test("divide", errs);

    errs = err_count;
    send_req(FN_DIV, 32'hffff_ff9c, 32'h0000_0000);
    send_req(FN_DIV, 32'h0000_1234, 32'h0000_0000);
    send_req(FN_DIVU, 32'h8000_0000, 32'h0000_0000);
    wait_drain();
    end_test("divide_by_zero", errs);

    errs = err_count;
    check_latency(FN_MUL, 32'h0000_0123, 32'hffff_ff00);
    check_latency(FN_DIVU, 32'h0001_0000, 32'h0000_0010);
    end_test("latency", errs);

    // fresh reset so the first tie is the one after reset
    errs = err_count;
    apply_reset();
    resp_rdy = 1'b0;
    send_req(FN_MUL, 32'hfedc_ba98, 32'h0000_0321);
    send_req(FN_DIV, 32'h7654_3210, 32'hffff_fc00);
    repeat (NUM_ITER + 8) @(negedge clk);
    assert (resp_val) else begin
      $display("mismatch resp_val first tie: got %h expected 1", resp_val);
      err_count++;
    end
    assert (resp_src == 1'b0) else begin
      $display("mismatch resp_src first tie: got %h expected 0", resp_src);
      err_count++;
    end
    resp_rdy = 1'b1;
    wait_drain();
    end_test("overlap", errs);

    if (err_count == 0 && tests_failed == 0) begin
      $display("passed %0d failed %0d", tests_passed, tests_failed);
      $display("Test completed successfully");
    end else begin
      $display("passed %0d failed %0d", tests_passed, tests_failed);
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
common/imuldiv_pkg.sv
imul/imul_iterative_dpath.sv
imul/imul_iterative.sv
idiv/idiv_iterative_dpath.sv
idiv/idiv_iterative.sv
hdl/imuldiv_port_router.sv
hdl/imuldiv_iterative.sv
testbench/tb_imuldiv.sv

// File: Makefile
# Verilator build and run for the iterative multiply/divide unit

VERILATOR ?= verilator
TOP       ?= tb_imuldiv
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
